// File: Makefile
VERILATOR  = verilator
TOP        = fir_tb
FILELIST   = fir.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/fir_properties.sv
`timescale 1ns/100ps
`include "fir_cfg.svh"

module fir_properties (
    input logic             axis_clk,
    input logic             axis_rst_n,
    input logic             sm_tvalid,
    input logic             sm_tready,
    input fir_pkg::sample_t sm_tdata,
    input logic             sm_tlast,
    input logic             bvalid,
    input logic             bready,
    input logic             running
);

    // result word frozen while the sink stalls
    out_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> $stable(sm_tdata) && $stable(sm_tlast))
        else $error("output stream changed while stalled");

    resp_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // no output between frames
    idle_quiet: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !running |-> !sm_tvalid)
        else $error("output valid while no frame runs");

endmodule

bind fir_top fir_properties u_props (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .bvalid     (bvalid),
    .bready     (bready),
    .running    (running)
);

// File: dv/fir_tb.sv
`timescale 1ns/100ps
`include "fir_cfg.svh"

module fir_tb;

    import fir_pkg::*;

    localparam int TOTAL_SAMPLES  = 11 + 40 + 40 + 20 + 15;   // all frame lengths
    localparam int TIMEOUT_CYCLES = TOTAL_SAMPLES * (`FIR_N_TAPS + 4) * 2 + 200;

    logic                   axis_clk;
    logic                   axis_rst_n;
    logic                   awvalid, awready, wvalid, wready, bvalid, bready;
    logic [`FIR_ADDR_W-1:0] awaddr;
    logic [`FIR_DATA_W-1:0] wdata;
    logic [1:0]             bresp;
    logic                   ss_tvalid, ss_tready, sm_tvalid, sm_tready, sm_tlast;
    sample_t                ss_tdata;
    sample_t                sm_tdata;

    logic [31:0] cur_taps [`FIR_N_TAPS];    // taps of the current frame
    logic [31:0] frame_x [$];               // input samples of the current frame
    integer      seed;
    integer      ready_seed;                // separate stream for sm_tready
    int          exp_len = 0;
    int          out_count = 0;
    int          err_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    logic        stall_mode = 1'b0;         // random sm_tready when set
    logic        frame_ended = 1'b0;        // last output of the frame seen

    fir_top DUT (.*);

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    // y[n] = sum of tap k times x[n-k], history before the frame is zero
    function automatic logic [31:0] expected_output(input int n);
        logic [31:0] acc;
        acc = '0;
        for (int k = 0; k < `FIR_N_TAPS && k <= n; k++) begin
            acc = acc + cur_taps[k] * frame_x[n - k];   // wraps modulo 2^32
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            err_count++;
        end
    endtask

    // called on a falling edge, returns on the falling edge after the response handshake
    task automatic write_reg(input logic [`FIR_ADDR_W-1:0] addr, input logic [31:0] data);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        bready  = 1'b0;                             // stall the response for a cycle
        do @(negedge axis_clk); while (!awready);
        check_value("wready", {31'b0, wready}, 32'h1);
        @(negedge axis_clk);                        // accepted on the edge before
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge axis_clk);
        check_value("bresp", {30'b0, bresp}, 32'h0);
        @(negedge axis_clk);                        // bvalid has to hold meanwhile
        bready = 1'b1;
        @(negedge axis_clk);
    endtask

    task automatic send_sample(input logic [31:0] data);
        ss_tvalid = 1'b1;
        ss_tdata  = data;
        while (!ss_tready) @(negedge axis_clk);
        @(negedge axis_clk);
        ss_tvalid = 1'b0;
    endtask

    task automatic random_frame(input int len);
        for (int k = 0; k < `FIR_N_TAPS; k++) begin
            cur_taps[k] = $random(seed);
        end
        frame_x.delete();
        repeat (len) frame_x.push_back($random(seed));
    endtask

    task automatic run_frame(input string name, input int len, input logic stall);
        int errs_before;
        errs_before = err_count;
        for (int k = 0; k < `FIR_N_TAPS; k++) begin
            write_reg(`FIR_ADDR_W'(`FIR_REG_TAP_BASE + 4 * k), cur_taps[k]);
        end
        write_reg(`FIR_ADDR_W'(`FIR_REG_LEN), 32'(len));
        exp_len     = len;
        out_count   = 0;
        frame_ended = 1'b0;
        write_reg(`FIR_ADDR_W'(`FIR_REG_CTRL), 32'h1);
        stall_mode  = stall;
        foreach (frame_x[i]) begin
            send_sample(frame_x[i]);
        end
        while (out_count < exp_len) @(posedge axis_clk);
        @(negedge axis_clk);                        // last handshake has completed
        stall_mode = 1'b0;
        // offer one more sample, the window must refuse it until the next start
        ss_tvalid = 1'b1;
        repeat (8) @(negedge axis_clk);
        ss_tvalid = 1'b0;
        if (err_count == errs_before) begin
            pass_count++;
            $display("%s: ok, %0d outputs checked", name, out_count);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // sink side: drives sm_tready and checks every output handshake
    initial begin
        logic [31:0] rnd;
        sm_tready = 1'b0;
        forever begin
            @(negedge axis_clk);
            rnd       = $random(ready_seed);
            sm_tready = stall_mode ? rnd[0] : 1'b1;
            if (frame_ended && (ss_tready || sm_tvalid)) begin
                $display("stream still active after the last output of the frame");
                err_count++;
                frame_ended = 1'b0;
            end
            if (sm_tvalid && sm_tready) begin
                if (out_count >= exp_len) begin
                    $display("extra output 0x%h beyond the frame length", sm_tdata);
                    err_count++;
                end else begin
                    check_value("sm_tdata", sm_tdata, expected_output(out_count));
                    check_value("sm_tlast", {31'b0, sm_tlast},
                                {31'b0, out_count == exp_len - 1});
                    frame_ended = sm_tlast;
                    out_count++;
                end
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge axis_clk);
            cycle_count++;
        end
        $display("timeout: frames did not complete within %0d clock cycles", cycle_count);
        $display("test failed");
        $finish;
    end

    initial begin
        seed       = 32'hc078;
        ready_seed = ~seed;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        bready     = 1'b1;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        repeat (5) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;
        @(negedge axis_clk);
        for (int k = 0; k < `FIR_N_TAPS; k++) begin
            cur_taps[k] = 32'(k + 1);
        end
        frame_x.delete();
        frame_x.push_back(32'd1);                   // impulse, then zeros
        repeat (10) frame_x.push_back(32'd0);
        run_frame("impulse response", 11, 1'b0);
        random_frame(40);
        run_frame("random frame", 40, 1'b0);
        random_frame(40);
        run_frame("back-pressure", 40, 1'b1);
        random_frame(20);
        run_frame("frame end", 20, 1'b1);
        random_frame(15);
        run_frame("second frame", 15, 1'b0);
        $display("summary: %0d ok, %0d with errors, %0d mismatches in total",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: fir.f
+incdir+verilog
verilog/fir_pkg.sv
verilog/fir_ctrl_regs.sv
verilog/fir_sample_window.sv
verilog/fir_mac_engine.sv
verilog/fir_top.sv
dv/fir_properties.sv
dv/fir_tb.sv

// File: verilog/fir_cfg.svh
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

`define FIR_N_TAPS        11        // filter length
`define FIR_DATA_W        32        // sample, tap and result word
`define FIR_ADDR_W        12        // AXI4-Lite address width

// register map
`define FIR_REG_CTRL      'h00      // bit 0 starts a frame
`define FIR_REG_LEN       'h10      // outputs per frame
`define FIR_REG_TAP_BASE  'h20      // tap i at base + 4*i

`endif

// File: verilog/fir_ctrl_regs.sv
`timescale 1ns/100ps
`include "fir_cfg.svh"

module fir_ctrl_regs (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`FIR_ADDR_W-1:0]  awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [`FIR_DATA_W-1:0]  wdata,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic                    frame_done,
    output fir_pkg::sample_t        taps [`FIR_N_TAPS],
    output fir_pkg::len_t           frame_len,
    output logic                    running,
    output logic                    start_pulse
);

    localparam logic [`FIR_ADDR_W-1:0] CTRL_ADDR = `FIR_ADDR_W'(`FIR_REG_CTRL);
    localparam logic [`FIR_ADDR_W-1:0] LEN_ADDR  = `FIR_ADDR_W'(`FIR_REG_LEN);
    localparam logic [`FIR_ADDR_W-1:0] TAP_ADDR  = `FIR_ADDR_W'(`FIR_REG_TAP_BASE);

    logic wr_rdy;       // shared awready / wready
    logic wr_en;        // address and data accepted this cycle
    logic start_wr;

    assign awready  = wr_rdy;
    assign wready   = wr_rdy;
    assign bresp    = 2'b00;                        // always OKAY
    assign wr_en    = wr_rdy & awvalid & wvalid;
    assign start_wr = wr_en && (awaddr == CTRL_ADDR) && wdata[0] && !running;

    // single outstanding write, response one cycle after acceptance
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_rdy <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            wr_rdy <= awvalid & wvalid & ~bvalid & ~wr_rdy;
            if (wr_en) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // run flag: set by start, cleared on the last output handshake
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            running     <= 1'b0;
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= start_wr;
            if (start_wr) begin
                running <= 1'b1;
            end else if (frame_done) begin
                running <= 1'b0;
            end
        end
    end

    // coefficients and length only change between frames
    always_ff @(posedge axis_clk) begin
        if (wr_en && !running) begin
            if (awaddr == LEN_ADDR) begin
                frame_len <= wdata;
            end
            for (int i = 0; i < `FIR_N_TAPS; i++) begin
                if (awaddr == TAP_ADDR + `FIR_ADDR_W'(4 * i)) begin
                    taps[i] <= wdata;
                end
            end
        end
    end

endmodule

// File: verilog/fir_mac_engine.sv
`timescale 1ns/100ps
`include "fir_cfg.svh"

module fir_mac_engine (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  logic                win_valid,
    output logic                win_take,
    output fir_pkg::tap_idx_t   win_idx,
    input  fir_pkg::sample_t    win_sample,
    input  fir_pkg::sample_t    taps [`FIR_N_TAPS],
    input  fir_pkg::len_t       frame_len,
    output logic                sm_tvalid,
    input  logic                sm_tready,
    output fir_pkg::sample_t    sm_tdata,
    output logic                sm_tlast,
    output logic                frame_done
);

    import fir_pkg::*;

    localparam tap_idx_t LAST_IDX = tap_idx_t'(`FIR_N_TAPS - 1);

    mac_state_t state;
    sample_t    acc;            // wraps modulo 2^32
    len_t       out_cnt;        // outputs already sent in this frame
    logic       out_hs;
    logic       last_out;

    assign win_take   = (state == IDLE) && win_valid;
    assign sm_tvalid  = (state == OUTPUT);
    assign sm_tdata   = acc;                    // held while in OUTPUT
    assign last_out   = (out_cnt + 32'd1 == frame_len);
    assign sm_tlast   = sm_tvalid && last_out;
    assign out_hs     = sm_tvalid && sm_tready;
    assign frame_done = out_hs && last_out;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state   <= IDLE;
            win_idx <= '0;
            out_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    win_idx <= '0;
                    if (win_valid) begin
                        state <= ACCUM;
                    end
                end
                ACCUM: begin
                    // one tap product per cycle
                    win_idx <= win_idx + tap_idx_t'(1);
                    if (win_idx == LAST_IDX) begin
                        state <= OUTPUT;
                    end
                end
                OUTPUT: begin
                    if (sm_tready) begin
                        state   <= IDLE;
                        out_cnt <= last_out ? '0 : out_cnt + 32'd1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (win_take) begin
            acc <= '0;
        end else if (state == ACCUM) begin
            acc <= acc + taps[win_idx] * win_sample;    // low 32 bits kept
        end
    end

endmodule

// File: verilog/fir_pkg.sv
`include "fir_cfg.svh"

package fir_pkg;

    // one signed data word, used for samples, taps and results
    typedef logic signed [`FIR_DATA_W-1:0] sample_t;

    typedef logic [$clog2(`FIR_N_TAPS)-1:0] tap_idx_t;   // history / tap index

    typedef logic [31:0] len_t;                         // frame length in outputs

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        OUTPUT
    } mac_state_t;

endpackage

// File: verilog/fir_sample_window.sv
`timescale 1ns/100ps
`include "fir_cfg.svh"

module fir_sample_window (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  logic                ss_tvalid,
    output logic                ss_tready,
    input  fir_pkg::sample_t    ss_tdata,
    input  logic                running,
    input  logic                start_pulse,
    input  logic                win_take,
    input  fir_pkg::tap_idx_t   win_idx,
    output logic                win_valid,
    output fir_pkg::sample_t    win_sample
);

    import fir_pkg::*;

    sample_t hist [`FIR_N_TAPS];    // hist[0] is the newest sample
    sample_t pend_data;             // accepted, not yet consumed
    logic    pending;
    logic    ss_hs;

    assign ss_tready  = running & ~pending;
    assign ss_hs      = ss_tvalid & ss_tready;
    assign win_valid  = pending;
    assign win_sample = hist[win_idx];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            pending <= 1'b0;
        end else if (start_pulse) begin
            pending <= ss_hs;           // drop anything left from the last frame
        end else if (ss_hs) begin
            pending <= 1'b1;
        end else if (win_take) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (ss_hs) begin
            pend_data <= ss_tdata;
        end
    end

    // history moves only when the engine takes a sample, so it is
    // steady for the whole accumulation
    always_ff @(posedge axis_clk) begin
        if (start_pulse) begin
            for (int i = 0; i < `FIR_N_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (win_take) begin
            hist[0] <= pend_data;
            for (int i = 1; i < `FIR_N_TAPS; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

endmodule

// File: verilog/fir_top.sv
`timescale 1ns/100ps
`include "fir_cfg.svh"

module fir_top (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`FIR_ADDR_W-1:0]  awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [`FIR_DATA_W-1:0]  wdata,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic                    ss_tvalid,
    output logic                    ss_tready,
    input  fir_pkg::sample_t        ss_tdata,
    output logic                    sm_tvalid,
    input  logic                    sm_tready,
    output fir_pkg::sample_t        sm_tdata,
    output logic                    sm_tlast
);

    import fir_pkg::*;

    sample_t  taps [`FIR_N_TAPS];
    len_t     frame_len;
    logic     running;
    logic     start_pulse;
    logic     win_valid;
    logic     win_take;
    tap_idx_t win_idx;
    sample_t  win_sample;
    logic     frame_done;

    // register block: taps and run control
    fir_ctrl_regs u_regs (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .frame_done  (frame_done),
        .taps        (taps),
        .frame_len   (frame_len),
        .running     (running),
        .start_pulse (start_pulse)
    );

    fir_sample_window u_window (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .ss_tvalid   (ss_tvalid),
        .ss_tready   (ss_tready),
        .ss_tdata    (ss_tdata),
        .running     (running),
        .start_pulse (start_pulse),
        .win_take    (win_take),
        .win_idx     (win_idx),
        .win_valid   (win_valid),
        .win_sample  (win_sample)
    );

    fir_mac_engine u_engine (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .win_valid   (win_valid),
        .win_take    (win_take),
        .win_idx     (win_idx),
        .win_sample  (win_sample),
        .taps        (taps),
        .frame_len   (frame_len),
        .sm_tvalid   (sm_tvalid),
        .sm_tready   (sm_tready),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast),
        .frame_done  (frame_done)
    );

endmodule
